// ==== src/fabric_pkg.sv ====
`default_nettype none

package fabric_pkg;

    // Bus widths shared by every channel
    localparam int ADDR_WIDTH = 32;
    localparam int INSTR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;

    // Start of the DDR-backed user region, boot ROM lives below it
    localparam logic [ADDR_WIDTH-1:0] DEFAULT_USER_BASE = 32'h0001_0000;

    // Destination of a routed fetch
    typedef enum logic {
        TARGET_ROM,
        TARGET_ICACHE
    } fetch_target_e;

    // Cache that owns the current DDR refill burst
    typedef enum logic {
        OWNER_ICACHE,
        OWNER_DCACHE
    } refill_owner_e;

    // Load port arbiter state
    typedef enum logic {
        MUX_IDLE,
        MUX_BURST
    } mux_state_e;

endpackage : fabric_pkg

`default_nettype wire

// ==== src/fetch_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_router #(
    parameter logic [fabric_pkg::ADDR_WIDTH-1:0] USER_BASE = fabric_pkg::DEFAULT_USER_BASE,
    parameter int FETCH_DEPTH = 4
) (
    input wire logic clk_i,
    input wire logic rst_n_i,

    // CPU fetch channel
    input wire logic fetch_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
    output logic fetch_req_ready_o,
    output logic fetch_rsp_valid_o,
    output logic [fabric_pkg::INSTR_WIDTH-1:0] fetch_instr_o,
    input wire logic fetch_rsp_ready_i,

    // Boot ROM channel
    output logic rom_req_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] rom_addr_o,
    input wire logic rom_req_ready_i,
    input wire logic rom_rsp_valid_i,
    input wire logic [fabric_pkg::INSTR_WIDTH-1:0] rom_instr_i,
    output logic rom_rsp_ready_o,

    // Instruction cache channel
    output logic ic_req_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] ic_addr_o,
    input wire logic ic_req_ready_i,
    input wire logic ic_rsp_valid_i,
    input wire logic [fabric_pkg::INSTR_WIDTH-1:0] ic_instr_i,
    output logic ic_rsp_ready_o,

    output logic region_switch_o
);

    localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
    localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

    // Order queue of outstanding fetch targets
    fabric_pkg::fetch_target_e order_q [FETCH_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic queue_full;
    logic queue_empty;
    logic sel_icache;
    logic push;
    logic pop;
    logic head_is_icache;
    logic rom_region_q;
    logic rom_fire;
    logic ic_fire;

    assign queue_full = (count_q == CNT_W'(FETCH_DEPTH));
    assign queue_empty = (count_q == '0);

    // Address decode against the user region base
    assign sel_icache = (fetch_addr_i >= USER_BASE);

    // Request path, blocked only when the order queue is full
    assign rom_req_valid_o = fetch_req_valid_i & ~sel_icache & ~queue_full;
    assign ic_req_valid_o = fetch_req_valid_i & sel_icache & ~queue_full;
    assign rom_addr_o = fetch_addr_i;
    assign ic_addr_o = fetch_addr_i;

    assign fetch_req_ready_o = ~queue_full & (sel_icache ? ic_req_ready_i : rom_req_ready_i);

    assign rom_fire = rom_req_valid_o & rom_req_ready_i;
    assign ic_fire = ic_req_valid_o & ic_req_ready_i;
    assign push = fetch_req_valid_i & fetch_req_ready_o;

    // Response path follows the oldest outstanding target
    assign head_is_icache = ~queue_empty & (order_q[rd_ptr_q] == fabric_pkg::TARGET_ICACHE);

    always_comb begin
        fetch_rsp_valid_o = 1'b0;
        fetch_instr_o = rom_instr_i;
        rom_rsp_ready_o = 1'b0;
        ic_rsp_ready_o = 1'b0;

        if (!queue_empty) begin
            if (head_is_icache) begin
                fetch_rsp_valid_o = ic_rsp_valid_i;
                fetch_instr_o = ic_instr_i;
                ic_rsp_ready_o = fetch_rsp_ready_i;
            end else begin
                fetch_rsp_valid_o = rom_rsp_valid_i;
                rom_rsp_ready_o = fetch_rsp_ready_i;
            end
        end
    end

    assign pop = fetch_rsp_valid_o & fetch_rsp_ready_i;

    // Queue storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            order_q[wr_ptr_q] <= sel_icache ? fabric_pkg::TARGET_ICACHE : fabric_pkg::TARGET_ROM;
        end
    end

    // Queue pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end

            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end

            case ({push, pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Tracks whether the last routed fetch went to the boot ROM
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rom_region_q <= 1'b1;
        end else if (rom_fire) begin
            rom_region_q <= 1'b1;
        end else if (ic_fire) begin
            rom_region_q <= 1'b0;
        end
    end

    // First cache fetch after leaving ROM
    assign region_switch_o = rom_region_q & ic_fire;

endmodule : fetch_router

`default_nettype wire

// ==== src/ddr_port_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module ddr_port_mux #(
    parameter logic [fabric_pkg::ADDR_WIDTH-1:0] USER_BASE = fabric_pkg::DEFAULT_USER_BASE
) (
    input wire logic clk_i,
    input wire logic rst_n_i,

    // Instruction cache refill
    input wire logic ir_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] ir_addr_i,
    output logic ir_req_ready_o,
    output logic ir_rsp_valid_o,
    output logic [fabric_pkg::DATA_WIDTH-1:0] ir_rsp_data_o,
    output logic ir_rsp_last_o,
    input wire logic ir_rsp_ready_i,

    // Data cache refill
    input wire logic dr_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] dr_addr_i,
    output logic dr_req_ready_o,
    output logic dr_rsp_valid_o,
    output logic [fabric_pkg::DATA_WIDTH-1:0] dr_rsp_data_o,
    output logic dr_rsp_last_o,
    input wire logic dr_rsp_ready_i,

    // DDR load port
    output logic ddr_ld_req_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] ddr_ld_addr_o,
    output logic ddr_ld_instr_o,
    input wire logic ddr_ld_req_ready_i,
    input wire logic ddr_ld_rsp_valid_i,
    input wire logic [fabric_pkg::DATA_WIDTH-1:0] ddr_ld_rsp_data_i,
    input wire logic ddr_ld_rsp_last_i,
    output logic ddr_ld_rsp_ready_o,

    // Data cache store
    input wire logic dw_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] dw_addr_i,
    input wire logic [fabric_pkg::DATA_WIDTH-1:0] dw_data_i,
    input wire logic [fabric_pkg::STRB_WIDTH-1:0] dw_strb_i,
    output logic dw_req_ready_o,

    // DDR store port
    output logic ddr_st_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] ddr_st_addr_o,
    output logic [fabric_pkg::DATA_WIDTH-1:0] ddr_st_data_o,
    output logic [fabric_pkg::STRB_WIDTH-1:0] ddr_st_strb_o,
    input wire logic ddr_st_ready_i
);

    fabric_pkg::mux_state_e state_q;
    fabric_pkg::mux_state_e state_d;
    fabric_pkg::refill_owner_e owner_q;
    fabric_pkg::refill_owner_e owner_sel;

    logic idle;
    logic req_fire;
    logic beat_fire;
    logic owner_is_icache;

    logic st_valid_q;
    logic [fabric_pkg::ADDR_WIDTH-1:0] st_addr_q;
    logic [fabric_pkg::DATA_WIDTH-1:0] st_data_q;
    logic [fabric_pkg::STRB_WIDTH-1:0] st_strb_q;
    logic st_fire;

    assign idle = (state_q == fabric_pkg::MUX_IDLE);

    // Data cache wins when both refills are pending
    assign owner_sel = dr_req_valid_i ? fabric_pkg::OWNER_DCACHE : fabric_pkg::OWNER_ICACHE;

    assign ddr_ld_req_valid_o = idle & (ir_req_valid_i | dr_req_valid_i);
    assign ddr_ld_addr_o = (dr_req_valid_i ? dr_addr_i : ir_addr_i) - USER_BASE;
    assign ddr_ld_instr_o = ddr_ld_req_valid_o & (owner_sel == fabric_pkg::OWNER_ICACHE);

    assign dr_req_ready_o = idle & ddr_ld_req_ready_i;
    assign ir_req_ready_o = idle & ~dr_req_valid_i & ddr_ld_req_ready_i;

    assign req_fire = ddr_ld_req_valid_o & ddr_ld_req_ready_i;

    // Beats go only to the owner of the current burst
    assign owner_is_icache = (owner_q == fabric_pkg::OWNER_ICACHE);

    always_comb begin
        ir_rsp_valid_o = 1'b0;
        dr_rsp_valid_o = 1'b0;
        ddr_ld_rsp_ready_o = 1'b0;

        if (!idle) begin
            if (owner_is_icache) begin
                ir_rsp_valid_o = ddr_ld_rsp_valid_i;
                ddr_ld_rsp_ready_o = ir_rsp_ready_i;
            end else begin
                dr_rsp_valid_o = ddr_ld_rsp_valid_i;
                ddr_ld_rsp_ready_o = dr_rsp_ready_i;
            end
        end
    end

    assign ir_rsp_data_o = ddr_ld_rsp_data_i;
    assign ir_rsp_last_o = ddr_ld_rsp_last_i;
    assign dr_rsp_data_o = ddr_ld_rsp_data_i;
    assign dr_rsp_last_o = ddr_ld_rsp_last_i;

    assign beat_fire = ddr_ld_rsp_valid_i & ddr_ld_rsp_ready_o;

    // Next state
    always_comb begin
        state_d = state_q;

        case (state_q)
            fabric_pkg::MUX_IDLE: begin
                if (req_fire) begin
                    state_d = fabric_pkg::MUX_BURST;
                end
            end

            fabric_pkg::MUX_BURST: begin
                // Burst ends on the last beat transfer
                if (beat_fire && ddr_ld_rsp_last_i) begin
                    state_d = fabric_pkg::MUX_IDLE;
                end
            end

            default: state_d = fabric_pkg::MUX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= fabric_pkg::MUX_IDLE;
            owner_q <= fabric_pkg::OWNER_ICACHE;
        end else begin
            state_q <= state_d;

            if (req_fire) begin
                owner_q <= owner_sel;
            end
        end
    end

    // One-entry store register, can accept while draining
    assign dw_req_ready_o = ~st_valid_q | ddr_st_ready_i;
    assign st_fire = dw_req_valid_i & dw_req_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            st_valid_q <= 1'b0;
        end else if (dw_req_ready_o) begin
            st_valid_q <= dw_req_valid_i;
        end
    end

    // Store payload, rebased into DDR space
    always_ff @(posedge clk_i) begin
        if (st_fire) begin
            st_addr_q <= dw_addr_i - USER_BASE;
            st_data_q <= dw_data_i;
            st_strb_q <= dw_strb_i;
        end
    end

    assign ddr_st_valid_o = st_valid_q;
    assign ddr_st_addr_o = st_addr_q;
    assign ddr_st_data_o = st_data_q;
    assign ddr_st_strb_o = st_strb_q;

endmodule : ddr_port_mux

`default_nettype wire

// ==== src/mem_fabric.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_fabric #(
    parameter logic [fabric_pkg::ADDR_WIDTH-1:0] USER_BASE = fabric_pkg::DEFAULT_USER_BASE,
    parameter int FETCH_DEPTH = 4
) (
    input wire logic clk_i,
    input wire logic rst_n_i,

    // CPU fetch
    input wire logic fetch_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
    output logic fetch_req_ready_o,
    output logic fetch_rsp_valid_o,
    output logic [fabric_pkg::INSTR_WIDTH-1:0] fetch_instr_o,
    input wire logic fetch_rsp_ready_i,

    // Boot ROM
    output logic rom_req_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] rom_addr_o,
    input wire logic rom_req_ready_i,
    input wire logic rom_rsp_valid_i,
    input wire logic [fabric_pkg::INSTR_WIDTH-1:0] rom_instr_i,
    output logic rom_rsp_ready_o,

    // Instruction cache fetch side
    output logic ic_req_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] ic_addr_o,
    input wire logic ic_req_ready_i,
    input wire logic ic_rsp_valid_i,
    input wire logic [fabric_pkg::INSTR_WIDTH-1:0] ic_instr_i,
    output logic ic_rsp_ready_o,
    output logic region_switch_o,

    // Instruction cache refill
    input wire logic ir_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] ir_addr_i,
    output logic ir_req_ready_o,
    output logic ir_rsp_valid_o,
    output logic [fabric_pkg::DATA_WIDTH-1:0] ir_rsp_data_o,
    output logic ir_rsp_last_o,
    input wire logic ir_rsp_ready_i,

    // Data cache refill
    input wire logic dr_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] dr_addr_i,
    output logic dr_req_ready_o,
    output logic dr_rsp_valid_o,
    output logic [fabric_pkg::DATA_WIDTH-1:0] dr_rsp_data_o,
    output logic dr_rsp_last_o,
    input wire logic dr_rsp_ready_i,

    // DDR load port
    output logic ddr_ld_req_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] ddr_ld_addr_o,
    output logic ddr_ld_instr_o,
    input wire logic ddr_ld_req_ready_i,
    input wire logic ddr_ld_rsp_valid_i,
    input wire logic [fabric_pkg::DATA_WIDTH-1:0] ddr_ld_rsp_data_i,
    input wire logic ddr_ld_rsp_last_i,
    output logic ddr_ld_rsp_ready_o,

    // Stores
    input wire logic dw_req_valid_i,
    input wire logic [fabric_pkg::ADDR_WIDTH-1:0] dw_addr_i,
    input wire logic [fabric_pkg::DATA_WIDTH-1:0] dw_data_i,
    input wire logic [fabric_pkg::STRB_WIDTH-1:0] dw_strb_i,
    output logic dw_req_ready_o,
    output logic ddr_st_valid_o,
    output logic [fabric_pkg::ADDR_WIDTH-1:0] ddr_st_addr_o,
    output logic [fabric_pkg::DATA_WIDTH-1:0] ddr_st_data_o,
    output logic [fabric_pkg::STRB_WIDTH-1:0] ddr_st_strb_o,
    input wire logic ddr_st_ready_i
);

    // Fetch side: ROM or instruction cache
    fetch_router #(
        .USER_BASE   ( USER_BASE   ),
        .FETCH_DEPTH ( FETCH_DEPTH )
    ) fetch_router_i (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .fetch_req_valid_i ( fetch_req_valid_i ),
        .fetch_addr_i      ( fetch_addr_i      ),
        .fetch_req_ready_o ( fetch_req_ready_o ),
        .fetch_rsp_valid_o ( fetch_rsp_valid_o ),
        .fetch_instr_o     ( fetch_instr_o     ),
        .fetch_rsp_ready_i ( fetch_rsp_ready_i ),
        .rom_req_valid_o   ( rom_req_valid_o   ),
        .rom_addr_o        ( rom_addr_o        ),
        .rom_req_ready_i   ( rom_req_ready_i   ),
        .rom_rsp_valid_i   ( rom_rsp_valid_i   ),
        .rom_instr_i       ( rom_instr_i       ),
        .rom_rsp_ready_o   ( rom_rsp_ready_o   ),
        .ic_req_valid_o    ( ic_req_valid_o    ),
        .ic_addr_o         ( ic_addr_o         ),
        .ic_req_ready_i    ( ic_req_ready_i    ),
        .ic_rsp_valid_i    ( ic_rsp_valid_i    ),
        .ic_instr_i        ( ic_instr_i        ),
        .ic_rsp_ready_o    ( ic_rsp_ready_o    ),
        .region_switch_o   ( region_switch_o   )
    );

    // Memory side: refill arbitration and stores
    ddr_port_mux #(
        .USER_BASE ( USER_BASE )
    ) ddr_port_mux_i (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .ir_req_valid_i     ( ir_req_valid_i     ),
        .ir_addr_i          ( ir_addr_i          ),
        .ir_req_ready_o     ( ir_req_ready_o     ),
        .ir_rsp_valid_o     ( ir_rsp_valid_o     ),
        .ir_rsp_data_o      ( ir_rsp_data_o      ),
        .ir_rsp_last_o      ( ir_rsp_last_o      ),
        .ir_rsp_ready_i     ( ir_rsp_ready_i     ),
        .dr_req_valid_i     ( dr_req_valid_i     ),
        .dr_addr_i          ( dr_addr_i          ),
        .dr_req_ready_o     ( dr_req_ready_o     ),
        .dr_rsp_valid_o     ( dr_rsp_valid_o     ),
        .dr_rsp_data_o      ( dr_rsp_data_o      ),
        .dr_rsp_last_o      ( dr_rsp_last_o      ),
        .dr_rsp_ready_i     ( dr_rsp_ready_i     ),
        .ddr_ld_req_valid_o ( ddr_ld_req_valid_o ),
        .ddr_ld_addr_o      ( ddr_ld_addr_o      ),
        .ddr_ld_instr_o     ( ddr_ld_instr_o     ),
        .ddr_ld_req_ready_i ( ddr_ld_req_ready_i ),
        .ddr_ld_rsp_valid_i ( ddr_ld_rsp_valid_i ),
        .ddr_ld_rsp_data_i  ( ddr_ld_rsp_data_i  ),
        .ddr_ld_rsp_last_i  ( ddr_ld_rsp_last_i  ),
        .ddr_ld_rsp_ready_o ( ddr_ld_rsp_ready_o ),
        .dw_req_valid_i     ( dw_req_valid_i     ),
        .dw_addr_i          ( dw_addr_i          ),
        .dw_data_i          ( dw_data_i          ),
        .dw_strb_i          ( dw_strb_i          ),
        .dw_req_ready_o     ( dw_req_ready_o     ),
        .ddr_st_valid_o     ( ddr_st_valid_o     ),
        .ddr_st_addr_o      ( ddr_st_addr_o      ),
        .ddr_st_data_o      ( ddr_st_data_o      ),
        .ddr_st_strb_o      ( ddr_st_strb_o      ),
        .ddr_st_ready_i     ( ddr_st_ready_i     )
    );

endmodule : mem_fabric

`default_nettype wire

// ==== verification/mem_fabric_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_fabric_model #(
    parameter logic [fabric_pkg::ADDR_WIDTH-1:0] USER_BASE = fabric_pkg::DEFAULT_USER_BASE
) ();

    // Expected CPU responses in request order
    logic [31:0] rsp_q [$];
    // Expected DDR stores as {strb, data, rebased addr}
    logic [67:0] st_q [$];

    // Instruction words returned by the modeled memories
    function automatic logic [31:0] rom_instr(input logic [31:0] addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h0000_0013;
    endfunction

    function automatic logic [31:0] ic_instr(input logic [31:0] addr);
        return (addr * 32'd2654435761) ^ 32'h0000_0073;
    endfunction

    // Refill data depends on DDR address and beat index
    function automatic logic [31:0] beat_data(input logic [31:0] addr, input int idx);
        return (addr + 32'(idx * 4)) ^ 32'hC3C3_0000;
    endfunction

    function automatic fabric_pkg::fetch_target_e route(input logic [31:0] addr);
        return (addr < USER_BASE) ? fabric_pkg::TARGET_ROM : fabric_pkg::TARGET_ICACHE;
    endfunction

    // Data cache has priority on the load port
    function automatic fabric_pkg::refill_owner_e owner_for(input logic dr_valid);
        return dr_valid ? fabric_pkg::OWNER_DCACHE : fabric_pkg::OWNER_ICACHE;
    endfunction

    task automatic push_fetch(input logic [31:0] addr);
        if (route(addr) == fabric_pkg::TARGET_ROM) begin
            rsp_q.push_back(rom_instr(addr));
        end else begin
            rsp_q.push_back(ic_instr(addr));
        end
    endtask

    task automatic pop_fetch(output logic [31:0] instr, output bit ok);
        ok = (rsp_q.size() > 0);
        instr = ok ? rsp_q.pop_front() : '0;
    endtask

    task automatic push_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        st_q.push_back({strb, data, addr - USER_BASE});
    endtask

    task automatic pop_store(output logic [67:0] v, output bit ok);
        ok = (st_q.size() > 0);
        v = ok ? st_q.pop_front() : '0;
    endtask

    function automatic logic [67:0] last_store();
        return (st_q.size() > 0) ? st_q[st_q.size()-1] : '0;
    endfunction

endmodule : mem_fabric_model

`default_nettype wire

// ==== verification/tb_mem_fabric.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_fabric;

    localparam logic [31:0] USER_BASE = fabric_pkg::DEFAULT_USER_BASE;
    localparam int N_FETCH = 80;
    localparam int N_REFILL = 20;
    localparam int N_STORE = 40;
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk_i = 1'b0;
    logic rst_n_i;
    logic fetch_req_valid_i, fetch_req_ready_o, fetch_rsp_valid_o, fetch_rsp_ready_i;
    logic [31:0] fetch_addr_i, fetch_instr_o;
    logic rom_req_valid_o, rom_req_ready_i, rom_rsp_valid_i, rom_rsp_ready_o;
    logic [31:0] rom_addr_o, rom_instr_i;
    logic ic_req_valid_o, ic_req_ready_i, ic_rsp_valid_i, ic_rsp_ready_o, region_switch_o;
    logic [31:0] ic_addr_o, ic_instr_i;
    logic ir_req_valid_i, ir_req_ready_o, ir_rsp_valid_o, ir_rsp_last_o, ir_rsp_ready_i;
    logic [31:0] ir_addr_i, ir_rsp_data_o;
    logic dr_req_valid_i, dr_req_ready_o, dr_rsp_valid_o, dr_rsp_last_o, dr_rsp_ready_i;
    logic [31:0] dr_addr_i, dr_rsp_data_o;
    logic ddr_ld_req_valid_o, ddr_ld_instr_o, ddr_ld_req_ready_i;
    logic ddr_ld_rsp_valid_i, ddr_ld_rsp_last_i, ddr_ld_rsp_ready_o;
    logic [31:0] ddr_ld_addr_o, ddr_ld_rsp_data_i;
    logic dw_req_valid_i, dw_req_ready_o, ddr_st_valid_o, ddr_st_ready_i;
    logic [31:0] dw_addr_i, dw_data_i, ddr_st_addr_o, ddr_st_data_o;
    logic [3:0] dw_strb_i, ddr_st_strb_o;

    // Testbench bookkeeping shared by driver and monitor
    logic [31:0] rom_pend [$];
    logic [31:0] ic_pend [$];
    int fetch_issued, rsp_count, ir_issued, dr_issued, refills_done, st_issued, st_out;
    bit fetch_fired, rom_rsp_fired, ic_rsp_fired, ir_fired, dr_fired, beat_fired, dw_fired;
    bit last_rom, burst_active, st_prev;
    fabric_pkg::refill_owner_e burst_owner;
    logic [31:0] burst_addr;
    int burst_len, beat_idx, cycles;

    mem_fabric #(.USER_BASE(USER_BASE), .FETCH_DEPTH(4)) mem_fabric_i (.*);

    mem_fabric_model #(.USER_BASE(USER_BASE)) model_i ();

    always #2 clk_i = ~clk_i;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH time %0t signal %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    // Word-aligned address on either side of the user base
    function automatic logic [31:0] rand_addr(input bit user);
        if (user) begin
            return USER_BASE + ($urandom & 32'h000F_FFFC);
        end
        return ($urandom % USER_BASE) & 32'hFFFF_FFFC;
    endfunction

    function automatic bit all_done();
        return rsp_count == N_FETCH && refills_done == 2 * N_REFILL && !burst_active
            && st_out == N_STORE;
    endfunction

    // Falling-edge driver for all channels and memory responders
    task automatic drive_inputs();
        rom_req_ready_i = ($urandom_range(0, 3) != 0);
        ic_req_ready_i = ($urandom_range(0, 3) != 0);
        fetch_rsp_ready_i = ($urandom_range(0, 3) != 0);
        ir_rsp_ready_i = ($urandom_range(0, 3) != 0);
        dr_rsp_ready_i = ($urandom_range(0, 3) != 0);
        ddr_ld_req_ready_i = ($urandom_range(0, 2) != 0);
        ddr_st_ready_i = ($urandom_range(0, 2) != 0);

        if (fetch_fired) begin
            fetch_req_valid_i = 1'b0;
            fetch_fired = 1'b0;
        end
        if (!fetch_req_valid_i && fetch_issued < N_FETCH && $urandom_range(0, 2) != 0) begin
            fetch_req_valid_i = 1'b1;
            fetch_addr_i = rand_addr($urandom_range(0, 1));
            fetch_issued++;
        end

        // ROM and instruction cache answer in order after random delays
        if (rom_rsp_fired) begin
            rom_rsp_valid_i = 1'b0;
            rom_rsp_fired = 1'b0;
        end
        if (!rom_rsp_valid_i && rom_pend.size() > 0 && $urandom_range(0, 2) == 0) begin
            rom_rsp_valid_i = 1'b1;
            rom_instr_i = model_i.rom_instr(rom_pend[0]);
        end
        if (ic_rsp_fired) begin
            ic_rsp_valid_i = 1'b0;
            ic_rsp_fired = 1'b0;
        end
        if (!ic_rsp_valid_i && ic_pend.size() > 0 && $urandom_range(0, 2) == 0) begin
            ic_rsp_valid_i = 1'b1;
            ic_instr_i = model_i.ic_instr(ic_pend[0]);
        end

        if (ir_fired) begin
            ir_req_valid_i = 1'b0;
            ir_fired = 1'b0;
        end
        if (!ir_req_valid_i && ir_issued < N_REFILL && $urandom_range(0, 3) == 0) begin
            ir_req_valid_i = 1'b1;
            ir_addr_i = rand_addr(1'b1);
            ir_issued++;
        end
        if (dr_fired) begin
            dr_req_valid_i = 1'b0;
            dr_fired = 1'b0;
        end
        if (!dr_req_valid_i && dr_issued < N_REFILL && $urandom_range(0, 3) == 0) begin
            dr_req_valid_i = 1'b1;
            dr_addr_i = rand_addr(1'b1);
            dr_issued++;
        end

        // DDR burst responder
        if (beat_fired) begin
            ddr_ld_rsp_valid_i = 1'b0;
            beat_fired = 1'b0;
        end
        if (burst_active && burst_len == 0) begin
            burst_len = $urandom_range(1, 4);
        end
        if (burst_active && !ddr_ld_rsp_valid_i && $urandom_range(0, 1) == 0) begin
            ddr_ld_rsp_valid_i = 1'b1;
            ddr_ld_rsp_data_i = model_i.beat_data(burst_addr, beat_idx);
            ddr_ld_rsp_last_i = (beat_idx == burst_len - 1);
        end

        if (dw_fired) begin
            dw_req_valid_i = 1'b0;
            dw_fired = 1'b0;
        end
        if (!dw_req_valid_i && st_issued < N_STORE && $urandom_range(0, 2) == 0) begin
            dw_req_valid_i = 1'b1;
            dw_addr_i = rand_addr(1'b1);
            dw_data_i = $urandom;
            dw_strb_i = 4'($urandom_range(1, 15));
            st_issued++;
        end
    endtask

    // Rising-edge monitor sees settled pre-edge values
    always @(posedge clk_i) begin : monitor
        logic [31:0] exp_instr;
        logic [67:0] st_v;
        bit ok;
        bit user;
        bit fetch_xfer;
        bit ld_fire;
        bit is_ic;

        if (rst_n_i) begin
            fetch_xfer = fetch_req_valid_i && fetch_req_ready_o;
            user = (model_i.route(fetch_addr_i) == fabric_pkg::TARGET_ICACHE);
            // Pulse only on a cache fetch that follows a ROM fetch or reset
            check("region_switch_o", fetch_xfer && user && last_rom, region_switch_o);
            if (fetch_xfer) begin
                check("ic request transfer", user, ic_req_valid_o && ic_req_ready_i);
                check("rom request transfer", !user, rom_req_valid_o && rom_req_ready_i);
                check(user ? "ic_addr_o" : "rom_addr_o", fetch_addr_i,
                      user ? ic_addr_o : rom_addr_o);
                model_i.push_fetch(fetch_addr_i);
                if (user) begin
                    ic_pend.push_back(fetch_addr_i);
                end else begin
                    rom_pend.push_back(fetch_addr_i);
                end
                last_rom = !user;
                fetch_fired = 1'b1;
            end else begin
                check("target transfer without fetch", 0,
                      (rom_req_valid_o && rom_req_ready_i) || (ic_req_valid_o && ic_req_ready_i));
            end
            if (rom_rsp_valid_i && rom_rsp_ready_o) begin
                void'(rom_pend.pop_front());
                rom_rsp_fired = 1'b1;
            end
            if (ic_rsp_valid_i && ic_rsp_ready_o) begin
                void'(ic_pend.pop_front());
                ic_rsp_fired = 1'b1;
            end
            if (fetch_rsp_valid_o && fetch_rsp_ready_i) begin
                model_i.pop_fetch(exp_instr, ok);
                if (!ok) begin
                    fail_run("CPU fetch response arrived with no fetch outstanding");
                end
                check("fetch_instr_o", exp_instr, fetch_instr_o);
                rsp_count++;
            end

            // Beats are steered only to the burst owner
            is_ic = (burst_owner == fabric_pkg::OWNER_ICACHE);
            check("ir_rsp_valid_o", burst_active && is_ic && ddr_ld_rsp_valid_i, ir_rsp_valid_o);
            check("dr_rsp_valid_o", burst_active && !is_ic && ddr_ld_rsp_valid_i, dr_rsp_valid_o);
            if (ddr_ld_rsp_valid_i && ddr_ld_rsp_ready_o) begin
                check(is_ic ? "ir_rsp_data_o" : "dr_rsp_data_o",
                      model_i.beat_data(burst_addr, beat_idx),
                      is_ic ? ir_rsp_data_o : dr_rsp_data_o);
                check(is_ic ? "ir_rsp_last_o" : "dr_rsp_last_o", beat_idx == burst_len - 1,
                      is_ic ? ir_rsp_last_o : dr_rsp_last_o);
                check("owner rsp ready", 1, is_ic ? ir_rsp_ready_i : dr_rsp_ready_i);
                beat_idx++;
                if (beat_idx == burst_len) begin
                    burst_active = 1'b0;
                end
                beat_fired = 1'b1;
            end

            ld_fire = ddr_ld_req_valid_o && ddr_ld_req_ready_i;
            if (ld_fire) begin
                check("refill request during burst", 0, burst_active);
                burst_owner = model_i.owner_for(dr_req_valid_i);
                is_ic = (burst_owner == fabric_pkg::OWNER_ICACHE);
                check("ddr_ld_addr_o", (is_ic ? ir_addr_i : dr_addr_i) - USER_BASE,
                      ddr_ld_addr_o);
                check("ddr_ld_instr_o", is_ic, ddr_ld_instr_o);
                check("ir refill transfer", is_ic, ir_req_valid_i && ir_req_ready_o);
                check("dr refill transfer", !is_ic, dr_req_valid_i && dr_req_ready_o);
                burst_active = 1'b1;
                burst_addr = ddr_ld_addr_o;
                burst_len = 0;
                beat_idx = 0;
                ir_fired = is_ic;
                dr_fired = !is_ic;
                refills_done++;
            end else begin
                check("refill transfer without DDR request", 0,
                      (ir_req_valid_i && ir_req_ready_o) || (dr_req_valid_i && dr_req_ready_o));
            end

            // Store register shows the newest store one cycle after its transfer
            if (st_prev) begin
                st_v = model_i.last_store();
                check("ddr_st_valid_o", 1, ddr_st_valid_o);
                check("ddr_st_addr_o", st_v[31:0], ddr_st_addr_o);
            end
            if (ddr_st_valid_o && ddr_st_ready_i) begin
                model_i.pop_store(st_v, ok);
                if (!ok) begin
                    fail_run("DDR store appeared with no store outstanding");
                end
                check("ddr_st_addr_o", st_v[31:0], ddr_st_addr_o);
                check("ddr_st_data_o", st_v[63:32], ddr_st_data_o);
                check("ddr_st_strb_o", st_v[67:64], ddr_st_strb_o);
                st_out++;
            end
            st_prev = dw_req_valid_i && dw_req_ready_o;
            if (st_prev) begin
                model_i.push_store(dw_addr_i, dw_data_i, dw_strb_i);
                dw_fired = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(31));
        rst_n_i = 1'b0;
        {fetch_req_valid_i, fetch_rsp_ready_i, rom_req_ready_i, rom_rsp_valid_i} = '0;
        {ic_req_ready_i, ic_rsp_valid_i, ir_req_valid_i, ir_rsp_ready_i} = '0;
        {dr_req_valid_i, dr_rsp_ready_i, ddr_ld_req_ready_i, ddr_ld_rsp_valid_i} = '0;
        {ddr_ld_rsp_last_i, dw_req_valid_i, ddr_st_ready_i, dw_strb_i} = '0;
        {fetch_addr_i, rom_instr_i, ic_instr_i, ir_addr_i, dr_addr_i} = '0;
        {ddr_ld_rsp_data_i, dw_addr_i, dw_data_i} = '0;
        last_rom = 1'b1;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        check("outputs idle after reset", 0,
              {fetch_rsp_valid_o, rom_req_valid_o, ic_req_valid_o, region_switch_o,
               ddr_ld_req_valid_o, ddr_st_valid_o, ir_rsp_valid_o, dr_rsp_valid_o});
        rst_n_i = 1'b1;
        cycles = 0;
        while (!all_done() && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            drive_inputs();
            cycles++;
        end
        if (all_done()) begin
            // Every target response consumed and nothing left on the outputs
            check("ROM responses left", 0, rom_pend.size());
            check("ic responses left", 0, ic_pend.size());
            check("fetch_rsp_valid_o", 0, fetch_rsp_valid_o);
            check("ddr_st_valid_o", 0, ddr_st_valid_o);
            $display("Verification passed");
            $finish;
        end else begin
            fail_run("Timeout waiting for all fetches, refills and stores to complete");
        end
    end

endmodule : tb_mem_fabric

`default_nettype wire

// ==== compile.f ====
src/fabric_pkg.sv
src/fetch_router.sv
src/ddr_port_mux.sv
src/mem_fabric.sv
verification/mem_fabric_model.sv
verification/tb_mem_fabric.sv

// ==== Bender.yml ====
package:
  name: mem_fabric

sources:
  - src/fabric_pkg.sv
  - src/fetch_router.sv
  - src/ddr_port_mux.sv
  - src/mem_fabric.sv
  - target: test
    files:
      - verification/mem_fabric_model.sv
      - verification/tb_mem_fabric.sv
